/* rv32i_types_pkg.sv */
`default_nettype none

package rv32i_types_pkg;

    // Major opcodes of RV32I, listed in full so anything outside the
    // ALU groups still decodes to a known name before it traps
    typedef enum logic [6:0] {
        op_load   = 7'b0000011,
        op_fence  = 7'b0001111,
        op_imm    = 7'b0010011,
        op_auipc  = 7'b0010111,
        op_store  = 7'b0100011,
        op_reg    = 7'b0110011,
        op_lui    = 7'b0110111,
        op_br     = 7'b1100011,
        op_jalr   = 7'b1100111,
        op_jal    = 7'b1101111,
        op_system = 7'b1110011
    } opcode_t;

    // funct3 of the ALU groups
    typedef enum logic [2:0] {
        f3_add_sub = 3'b000,
        f3_sll     = 3'b001,
        f3_slt     = 3'b010,
        f3_sltu    = 3'b011,
        f3_xor     = 3'b100,
        f3_shr     = 3'b101,
        f3_or      = 3'b110,
        f3_and     = 3'b111
    } funct3_t;

    // funct7 values, alt selects SUB and SRA / SRAI
    typedef enum logic [6:0] {
        f7_base = 7'b0000000,
        f7_alt  = 7'b0100000
    } funct7_t;

    // Internal ALU operation
    typedef enum logic [3:0] {
        alu_add,
        alu_sub,
        alu_sll,
        alu_slt,
        alu_sltu,
        alu_xor,
        alu_srl,
        alu_sra,
        alu_or,
        alu_and
    } alu_op_t;

    // R-type layout, overlays the whole instruction word
    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        opcode_t    opcode;
    } inst_fields_t;

    // Decoder output carried down the pipe
    typedef struct packed {
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [4:0]  rd;
        alu_op_t     alu_op;
        logic        use_imm;
        logic [31:0] imm;
        logic        writes_rd;
        logic        trap;
    } decoded_t;

endpackage

`default_nettype wire

/* rv32i_packet_pkg.sv */
`default_nettype none

package rv32i_packet_pkg;

    import rv32i_types_pkg::*;

    // Decode and read stage packet
    // Operand data stays zero until the read stage fills it in
    typedef struct packed {
        logic        valid;
        logic [31:0] inst;
        decoded_t    dcd;
        logic [31:0] rs1_data;
        logic [31:0] rs2_data;
    } read_pkt_t;

    // Execute stage packet, operands here are the forwarded ones
    typedef struct packed {
        read_pkt_t   pkt;
        logic [31:0] result;
    } exec_pkt_t;

    // Per-instruction retire report, RVFI style
    typedef struct packed {
        logic [63:0] order;
        logic [31:0] inst;
        logic        trap;
        logic [4:0]  rs1_addr;
        logic [4:0]  rs2_addr;
        logic [31:0] rs1_rdata;
        logic [31:0] rs2_rdata;
        logic [4:0]  rd_addr;
        logic [31:0] rd_wdata;
        logic        load_regfile;
    } commit_pkt_t;

    // Register file write port
    typedef struct packed {
        logic        en;
        logic [4:0]  addr;
        logic [31:0] data;
    } wb_t;

endpackage

`default_nettype wire

/* decode_stage.sv */
`default_nettype none
`timescale 1ns/1ps

module decode_stage
    import rv32i_types_pkg::*;
    import rv32i_packet_pkg::*;
#(
    parameter int REG_COUNT = 32
) (
    input  logic        itf,
    input  logic        arst_n,
    input  logic        inst_valid,
    input  logic [31:0] inst,
    output read_pkt_t   dec
);

    inst_fields_t f;
    decoded_t     d;
    logic         legal;
    logic         bad_reg;

    // Plain funct3 mapping, SUB and SRA are patched in afterwards
    function automatic alu_op_t base_op(input logic [2:0] funct3);
        case (funct3)
            f3_add_sub: return alu_add;
            f3_sll:     return alu_sll;
            f3_slt:     return alu_slt;
            f3_sltu:    return alu_sltu;
            f3_xor:     return alu_xor;
            f3_shr:     return alu_srl;
            f3_or:      return alu_or;
            default:    return alu_and;
        endcase
    endfunction

    always_comb begin
        f = inst_fields_t'(inst);
        d = '0;
        legal = 1'b1;
        d.rs1 = f.rs1;
        d.rs2 = f.rs2;
        d.rd = f.rd;
        // I immediate, sign bit is inst[31]
        d.imm = {{20{inst[31]}}, inst[31:20]};
        d.alu_op = base_op(f.funct3);
        case (f.opcode)
            op_reg: begin
                // Only ADD/SUB and SRL/SRA accept the alt funct7
                if (f.funct7 == f7_alt && f.funct3 == f3_add_sub) begin
                    d.alu_op = alu_sub;
                end else if (f.funct7 == f7_alt && f.funct3 == f3_shr) begin
                    d.alu_op = alu_sra;
                end else if (f.funct7 != f7_base) begin
                    legal = 1'b0;
                end
            end
            op_imm: begin
                d.use_imm = 1'b1;
                // No second source, report x0
                d.rs2 = '0;
                // Shift-immediates reuse funct7 as the upper imm bits
                if (f.funct3 == f3_sll && f.funct7 != f7_base) begin
                    legal = 1'b0;
                end else if (f.funct3 == f3_shr) begin
                    if (f.funct7 == f7_alt) begin
                        d.alu_op = alu_sra;
                    end else if (f.funct7 != f7_base) begin
                        legal = 1'b0;
                    end
                end
            end
            default: legal = 1'b0;
        endcase
        // RV32E builds have fewer registers
        bad_reg = (d.rs1 >= REG_COUNT) || (d.rs2 >= REG_COUNT) || (d.rd >= REG_COUNT);
        d.trap = !legal || bad_reg;
        // x0 is never written
        d.writes_rd = !d.trap && (d.rd != 5'd0);
    end

    // Stage register, bubbles go through as well
    always_ff @(posedge itf or negedge arst_n) begin
        if (!arst_n) begin
            dec <= '0;
        end else begin
            dec <= '{valid: inst_valid, inst: inst, dcd: d, rs1_data: '0, rs2_data: '0};
        end
    end

endmodule

`default_nettype wire

/* reg_read_stage.sv */
`default_nettype none
`timescale 1ns/1ps

module reg_read_stage
    import rv32i_packet_pkg::*;
#(
    parameter int REG_COUNT = 32
) (
    input  logic      itf,
    input  logic      arst_n,
    input  read_pkt_t dec,
    input  wb_t       wb,
    output read_pkt_t rd_pkt
);

    localparam int IDX_W = $clog2(REG_COUNT);

    logic [31:0] regs [REG_COUNT];
    logic [31:0] rs1_val;
    logic [31:0] rs2_val;

    // Read with bypass from the write landing on this same edge
    function automatic logic [31:0] read_reg(input logic [4:0] addr);
        logic [31:0] val;
        if (addr == 5'd0 || addr >= REG_COUNT) begin
            // x0, and indices past the file which only traps carry
            val = '0;
        end else if (wb.en && wb.addr == addr) begin
            val = wb.data;
        end else begin
            val = regs[addr[IDX_W-1:0]];
        end
        return val;
    endfunction

    // Register file, entry 0 is never written and stays zero
    always_ff @(posedge itf or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (wb.en && wb.addr != 5'd0 && wb.addr < REG_COUNT) begin
            regs[wb.addr[IDX_W-1:0]] <= wb.data;
        end
    end

    always_comb begin
        rs1_val = read_reg(dec.dcd.rs1);
        rs2_val = read_reg(dec.dcd.rs2);
    end

    // Operands travel with the decoded instruction
    always_ff @(posedge itf or negedge arst_n) begin
        if (!arst_n) begin
            rd_pkt <= '0;
        end else begin
            rd_pkt <= '{
                valid:    dec.valid,
                inst:     dec.inst,
                dcd:      dec.dcd,
                rs1_data: rs1_val,
                rs2_data: rs2_val
            };
        end
    end

endmodule

`default_nettype wire

/* execute_stage.sv */
`default_nettype none
`timescale 1ns/1ps

module execute_stage
    import rv32i_types_pkg::*;
    import rv32i_packet_pkg::*;
(
    input  logic      itf,
    input  logic      arst_n,
    input  read_pkt_t rd_pkt,
    output exec_pkt_t ex_pkt
);

    read_pkt_t   fwd_pkt;
    logic        fwd_rs1;
    logic        fwd_rs2;
    logic [31:0] op_a;
    logic [31:0] op_b;
    logic [31:0] alu_out;

    // Previous instruction still sits in ex_pkt and has not been written back
    // writes_rd is already low for rd == 0, so x0 never matches
    always_comb begin
        fwd_rs1 = ex_pkt.pkt.valid && ex_pkt.pkt.dcd.writes_rd
               && (ex_pkt.pkt.dcd.rd == rd_pkt.dcd.rs1);
        fwd_rs2 = ex_pkt.pkt.valid && ex_pkt.pkt.dcd.writes_rd
               && (ex_pkt.pkt.dcd.rd == rd_pkt.dcd.rs2);
    end

    // Forwarded values replace the read ones, also in the commit report
    always_comb begin
        fwd_pkt = rd_pkt;
        if (fwd_rs1) begin
            fwd_pkt.rs1_data = ex_pkt.result;
        end
        if (fwd_rs2) begin
            fwd_pkt.rs2_data = ex_pkt.result;
        end
    end

    assign op_a = fwd_pkt.rs1_data;
    // Immediate forms ignore rs2
    assign op_b = fwd_pkt.dcd.use_imm ? fwd_pkt.dcd.imm : fwd_pkt.rs2_data;

    // Shift amount is the low five bits of operand b
    always_comb begin
        case (fwd_pkt.dcd.alu_op)
            alu_add:  alu_out = op_a + op_b;
            alu_sub:  alu_out = op_a - op_b;
            alu_sll:  alu_out = op_a << op_b[4:0];
            alu_slt:  alu_out = {31'd0, $signed(op_a) < $signed(op_b)};
            alu_sltu: alu_out = {31'd0, op_a < op_b};
            alu_xor:  alu_out = op_a ^ op_b;
            alu_srl:  alu_out = op_a >> op_b[4:0];
            alu_sra:  alu_out = $unsigned($signed(op_a) >>> op_b[4:0]);
            alu_or:   alu_out = op_a | op_b;
            alu_and:  alu_out = op_a & op_b;
            default:  alu_out = '0;
        endcase
    end

    always_ff @(posedge itf or negedge arst_n) begin
        if (!arst_n) begin
            ex_pkt <= '0;
        end else begin
            ex_pkt <= '{pkt: fwd_pkt, result: alu_out};
        end
    end

endmodule

`default_nettype wire

/* commit_stage.sv */
`default_nettype none
`timescale 1ns/1ps

module commit_stage
    import rv32i_packet_pkg::*;
(
    input  logic        itf,
    input  logic        arst_n,
    input  exec_pkt_t   ex_pkt,
    output wb_t         wb,
    output logic        commit_valid,
    output commit_pkt_t commit
);

    logic        wr_en;
    logic [63:0] order_q;

    // Writeback goes straight from the execute register
    assign wr_en = ex_pkt.pkt.valid && ex_pkt.pkt.dcd.writes_rd;
    assign wb = '{en: wr_en, addr: ex_pkt.pkt.dcd.rd, data: ex_pkt.result};

    always_ff @(posedge itf or negedge arst_n) begin
        if (!arst_n) begin
            commit_valid <= 1'b0;
            commit <= '0;
            order_q <= '0;
        end else begin
            commit_valid <= ex_pkt.pkt.valid;
            // rd_wdata reads zero whenever nothing is written
            commit <= '{
                order:        order_q,
                inst:         ex_pkt.pkt.inst,
                trap:         ex_pkt.pkt.dcd.trap,
                rs1_addr:     ex_pkt.pkt.dcd.rs1,
                rs2_addr:     ex_pkt.pkt.dcd.rs2,
                rs1_rdata:    ex_pkt.pkt.rs1_data,
                rs2_rdata:    ex_pkt.pkt.rs2_data,
                rd_addr:      ex_pkt.pkt.dcd.rd,
                rd_wdata:     wr_en ? ex_pkt.result : 32'd0,
                load_regfile: wr_en
            };
            // Traps count as retired too
            if (ex_pkt.pkt.valid) begin
                order_q <= order_q + 64'd1;
            end
        end
    end

endmodule

`default_nettype wire

/* rv_core.sv */
`default_nettype none
`timescale 1ns/1ps

module rv_core
    import rv32i_packet_pkg::*;
#(
    // 32 for RV32I, 16 for RV32E
    parameter int REG_COUNT = 32
) (
    input  logic        itf,
    input  logic        arst_n,
    input  logic        inst_valid,
    input  logic [31:0] inst,
    output logic        commit_valid,
    output commit_pkt_t commit
);

    read_pkt_t dec_pkt;
    read_pkt_t rd_pkt;
    exec_pkt_t ex_pkt;
    wb_t       wb;

    decode_stage #(
        .REG_COUNT (REG_COUNT)
    ) decode0 (
        .itf        (itf),
        .arst_n     (arst_n),
        .inst_valid (inst_valid),
        .inst       (inst),
        .dec        (dec_pkt)
    );

    // Write port comes back from commit
    reg_read_stage #(
        .REG_COUNT (REG_COUNT)
    ) read0 (
        .itf    (itf),
        .arst_n (arst_n),
        .dec    (dec_pkt),
        .wb     (wb),
        .rd_pkt (rd_pkt)
    );

    execute_stage exec0 (
        .itf    (itf),
        .arst_n (arst_n),
        .rd_pkt (rd_pkt),
        .ex_pkt (ex_pkt)
    );

    commit_stage commit0 (
        .itf          (itf),
        .arst_n       (arst_n),
        .ex_pkt       (ex_pkt),
        .wb           (wb),
        .commit_valid (commit_valid),
        .commit       (commit)
    );

endmodule

`default_nettype wire

/* commit_monitor.sv */
`default_nettype none
`timescale 1ns/1ps

module commit_monitor
    import rv32i_packet_pkg::*;
#(
    parameter int REG_COUNT = 32
) (
    input  logic        itf,
    input  logic        arst_n,
    input  logic        inst_valid,
    input  logic [31:0] inst,
    input  logic        commit_valid,
    input  commit_pkt_t commit,
    input  logic        end_of_test,
    output int          error_count,
    output int          commit_count,
    output int          issue_count
);

    localparam logic [6:0] OPC_REG = 7'b0110011;
    localparam logic [6:0] OPC_IMM = 7'b0010011;
    localparam logic [6:0] F7_ALT = 7'h20;
    // Issue to commit, counted in clock cycles
    localparam int LATENCY = 4;

    // Issued instruction waiting for its commit
    typedef struct packed {
        logic [31:0] inst;
        logic [31:0] cycle;
    } issue_t;

    issue_t      pend_q[$];
    logic [31:0] model_regs [32];
    logic [31:0] cycle;
    logic [63:0] exp_order;
    logic        end_done;

    initial begin
        error_count = 0;
        commit_count = 0;
        issue_count = 0;
        end_done = 1'b0;
    end

    // x0 and indices past the file read zero
    function automatic logic [31:0] model_read(input logic [4:0] addr);
        return (addr == 5'd0 || addr >= REG_COUNT) ? 32'd0 : model_regs[addr];
    endfunction

    // ISA result, shifts use the low five bits of b
    function automatic logic [31:0] alu_model(input logic is_reg, input logic [2:0] f3,
                                              input logic alt, input logic [31:0] a,
                                              input logic [31:0] b);
        logic [4:0]  sh;
        logic [31:0] res;
        sh = b[4:0];
        case (f3)
            3'd0: res = (is_reg && alt) ? a - b : a + b;
            3'd1: res = a << sh;
            // Differing signs decide by the sign of a
            3'd2: res = (a[31] != b[31]) ? {31'd0, a[31]} : {31'd0, a < b};
            3'd3: res = {31'd0, a < b};
            3'd4: res = a ^ b;
            // Fill vacated upper bits with the sign for SRA
            3'd5: res = (a >> sh) | ((alt && a[31]) ? ~(32'hffff_ffff >> sh) : 32'd0);
            3'd6: res = a | b;
            default: res = a & b;
        endcase
        return res;
    endfunction

    task automatic check_field(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        if (got !== exp) begin
            $display("ERROR %0t commit.%s got %0h expected %0h", $time, name, got, exp);
            error_count++;
        end
    endtask

    // Run the oldest issued instruction on the model and compare
    task automatic retire(input issue_t ent);
        logic [31:0] w;
        logic [6:0]  opc;
        logic [6:0]  f7;
        logic [2:0]  f3;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [4:0]  rd;
        logic [31:0] a;
        logic [31:0] b_reg;
        logic [31:0] res;
        logic        ok;
        logic        wr;
        w = ent.inst;
        opc = w[6:0];
        f3 = w[14:12];
        f7 = w[31:25];
        rs1 = w[19:15];
        rd = w[11:7];
        // Immediate forms have no second source
        rs2 = (opc == OPC_IMM) ? 5'd0 : w[24:20];
        ok = 1'b0;
        if (opc == OPC_REG) begin
            ok = (f7 == 7'd0) || (f7 == F7_ALT && (f3 == 3'd0 || f3 == 3'd5));
        end else if (opc == OPC_IMM) begin
            if (f3 == 3'd1) begin
                ok = (f7 == 7'd0);
            end else if (f3 == 3'd5) begin
                ok = (f7 == 7'd0) || (f7 == F7_ALT);
            end else begin
                ok = 1'b1;
            end
        end
        if (rs1 >= REG_COUNT || rs2 >= REG_COUNT || rd >= REG_COUNT) begin
            ok = 1'b0;
        end
        a = model_read(rs1);
        b_reg = model_read(rs2);
        res = alu_model(opc == OPC_REG, f3, f7 == F7_ALT, a,
                        (opc == OPC_IMM) ? {{20{w[31]}}, w[31:20]} : b_reg);
        wr = ok && (rd != 5'd0);
        if (cycle - ent.cycle != LATENCY) begin
            $display("ERROR %0t commit latency got %0d expected %0d cycles",
                     $time, cycle - ent.cycle, LATENCY);
            error_count++;
        end
        check_field("order", commit.order, exp_order);
        check_field("inst", 64'(commit.inst), 64'(w));
        check_field("trap", 64'(commit.trap), 64'(!ok));
        check_field("rs1_addr", 64'(commit.rs1_addr), 64'(rs1));
        check_field("rs2_addr", 64'(commit.rs2_addr), 64'(rs2));
        check_field("rs1_rdata", 64'(commit.rs1_rdata), 64'(a));
        check_field("rs2_rdata", 64'(commit.rs2_rdata), 64'(b_reg));
        check_field("rd_addr", 64'(commit.rd_addr), 64'(rd));
        check_field("rd_wdata", 64'(commit.rd_wdata), wr ? 64'(res) : 64'd0);
        check_field("load_regfile", 64'(commit.load_regfile), 64'(wr));
        exp_order = exp_order + 64'd1;
        // Traps and x0 leave the model alone
        if (wr) begin
            model_regs[rd] = res;
        end
    endtask

    // Sample on the falling edge, half a cycle clear of any update
    always @(negedge itf) begin
        if (!arst_n) begin
            for (int i = 0; i < 32; i++) begin
                model_regs[i] = '0;
            end
            pend_q.delete();
            exp_order = '0;
            cycle = '0;
        end else begin
            cycle = cycle + 32'd1;
            if (commit_valid) begin
                if (pend_q.size() == 0) begin
                    $display("ERROR %0t commit arrived with no instruction in flight", $time);
                    error_count++;
                end else begin
                    retire(pend_q.pop_front());
                end
                commit_count++;
            end
            if (inst_valid) begin
                pend_q.push_back('{inst: inst, cycle: cycle});
                issue_count++;
            end
            if (end_of_test && !end_done) begin
                end_done = 1'b1;
                if (pend_q.size() != 0 || commit_count != issue_count) begin
                    $display("ERROR %0t %0d issued but %0d committed, %0d still in flight",
                             $time, issue_count, commit_count, pend_q.size());
                    error_count++;
                end
            end
        end
    end

endmodule

`default_nettype wire

/* tb_rv_core.sv */
`default_nettype none
`timescale 1ns/1ps

module tb_rv_core
    import rv32i_packet_pkg::*;
();

    localparam int REG_COUNT = 32;
    localparam int CLK_PERIOD = 4;
    localparam int RESET_CYCLES = 4;
    localparam int NUM_INSTS = 2000;
    localparam int IDLE_CYCLES = 10;
    // Two cycles per instruction leaves room for bubbles, plus some slack
    localparam int WATCHDOG_CYCLES = NUM_INSTS * 2 + 100;
    localparam logic [31:0] SEED = 32'h50a5_6b7a;
    localparam logic [6:0] OPC_REG = 7'b0110011;
    localparam logic [6:0] OPC_IMM = 7'b0010011;

    logic        itf;
    logic        arst_n;
    logic        inst_valid;
    logic [31:0] inst;
    logic        commit_valid;
    commit_pkt_t commit;
    logic        end_of_test;
    int          error_count;
    int          commit_count;
    int          issue_count;
    logic [31:0] rng;
    int          sent;

    rv_core #(
        .REG_COUNT (REG_COUNT)
    ) dut0 (
        .itf          (itf),
        .arst_n       (arst_n),
        .inst_valid   (inst_valid),
        .inst         (inst),
        .commit_valid (commit_valid),
        .commit       (commit)
    );

    // Checker sits beside the DUT on the same pins
    commit_monitor #(
        .REG_COUNT (REG_COUNT)
    ) mon0 (
        .itf          (itf),
        .arst_n       (arst_n),
        .inst_valid   (inst_valid),
        .inst         (inst),
        .commit_valid (commit_valid),
        .commit       (commit),
        .end_of_test  (end_of_test),
        .error_count  (error_count),
        .commit_count (commit_count),
        .issue_count  (issue_count)
    );

    // 4 ns period
    always #(CLK_PERIOD / 2) itf = ~itf;

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    task automatic draw(output logic [31:0] r);
        rng = xorshift32(rng);
        r = rng;
    endtask

    // Mostly x0..x3 so neighbouring instructions depend on each other
    function automatic logic [4:0] pick_reg(input logic [31:0] r);
        return (r[2:0] != 3'd0) ? {3'd0, r[4:3]} : r[9:5];
    endfunction

    task automatic build_inst(output logic [31:0] word);
        logic [31:0] r;
        logic [31:0] f;
        logic [2:0]  f3;
        logic [6:0]  f7;
        logic [4:0]  rs1;
        logic [4:0]  rd;
        draw(r);
        draw(f);
        f3 = f[2:0];
        rs1 = pick_reg(r >> 9);
        rd = pick_reg(r >> 19);
        // Base or alt funct7, now and then an odd one that must trap
        f7 = ((f3 == 3'd0 || f3 == 3'd5) && f[3]) ? 7'h20 : 7'h00;
        if (f[7:4] == 4'd0) begin
            f7 = f[14:8];
        end
        if (r[7:0] < 8'd13) begin
            // About 5% raw words, nearly all illegal
            draw(word);
        end else if (r[8]) begin
            word = {f7, pick_reg(f >> 15), rs1, f3, rd, OPC_REG};
        end else if (f3 == 3'd1 || f3 == 3'd5) begin
            // Shift-immediate, shamt in the rs2 field
            word = {f7, f[24:20], rs1, f3, rd, OPC_IMM};
        end else begin
            word = {f[31:20], rs1, f3, rd, OPC_IMM};
        end
    endtask

    // One stimulus slot, idle about a quarter of the time
    task automatic issue_one();
        logic [31:0] r;
        logic [31:0] word;
        draw(r);
        if (r[1:0] == 2'd0) begin
            inst_valid = 1'b0;
            // Junk word under a low strobe
            inst = r;
        end else begin
            build_inst(word);
            inst_valid = 1'b1;
            inst = word;
            sent++;
        end
    endtask

    initial begin
        itf = 1'b0;
        arst_n = 1'b0;
        inst_valid = 1'b0;
        inst = '0;
        end_of_test = 1'b0;
        rng = SEED;
        sent = 0;
        repeat (RESET_CYCLES) @(posedge itf);
        #0.5;
        arst_n = 1'b1;
        while (sent < NUM_INSTS) begin
            @(posedge itf);
            #0.5;
            issue_one();
        end
        @(posedge itf);
        #0.5;
        inst_valid = 1'b0;
        // Drain the pipe
        repeat (IDLE_CYCLES) @(posedge itf);
        #0.5;
        end_of_test = 1'b1;
        repeat (2) @(posedge itf);
        $display("errors %0d, commits %0d, issued %0d", error_count, commit_count, issue_count);
        if (error_count == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

    // Watchdog
    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("Timeout: run still going after %0d cycles", WATCHDOG_CYCLES);
        $display("=== FAIL ===");
        $finish;
    end

endmodule

`default_nettype wire

/* list.f */
rv32i_types_pkg.sv
rv32i_packet_pkg.sv
decode_stage.sv
reg_read_stage.sv
execute_stage.sv
commit_stage.sv
rv_core.sv
commit_monitor.sv
tb_rv_core.sv

/* run.sh */
#!/usr/bin/env bash
# Build and run the core testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
BIN=sim_tb_rv_core

rm -rf obj_dir

verilator --binary --timing -Wno-fatal --top-module tb_rv_core -o "$BIN" -f list.f
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit 1
fi

./obj_dir/"$BIN" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -qx "=== PASS ===" "$LOG"; then
    exit 0
else
    echo "Pass message not found in $LOG"
    exit 1
fi
